//--- src/ap_parameters.sv
// data widths and frame geometry shared by the spectral magnitude RTL, referenced by scoped name
package ap_parameters;

    // ----------------------------------------
    // datapath widths
    // ----------------------------------------

    // one signed fft part, real or imag
    localparam int FFT_DATA_WIDTH = 16;

    // real^2 + imag^2, worst case 2 * 2^30 = 2^31
    localparam int SQ_WIDTH = 2 * FFT_DATA_WIDTH;

    // floor root of the sum, max 46340
    localparam int MAG_WIDTH = SQ_WIDTH / 2;

    // band energy, sum of up to 64 magnitudes
    localparam int MEL_DATA_WIDTH = 32;

    // ----------------------------------------
    // frame geometry
    // ----------------------------------------

    localparam int FFT_BINS      = 64;                 // bins per frame
    localparam int BIN_IDX_WIDTH = $clog2(FFT_BINS);   // bin counter, 6 bits

endpackage

//--- src/mel_band_pkg.sv
// band table and accumulator state type for the rectangular band energy stage
package mel_band_pkg;

    // ----------------------------------------
    // band layout
    // ----------------------------------------

    localparam int NUM_BANDS      = 8;
    localparam int BAND_IDX_WIDTH = $clog2(NUM_BANDS);   // 3 bits

    // last bin of each band, inclusive
    // band 0 starts at bin 0, band n starts at BAND_LAST_BIN[n-1] + 1
    // bins 53..63 fall outside every band
    localparam logic [ap_parameters::BIN_IDX_WIDTH-1:0] BAND_LAST_BIN [NUM_BANDS] = '{
        6'd1,    // band 0: bins 0..1
        6'd3,    // band 1: bins 2..3
        6'd6,    // band 2: bins 4..6
        6'd10,   // band 3: bins 7..10
        6'd16,   // band 4: bins 11..16
        6'd24,   // band 5: bins 17..24
        6'd36,   // band 6: bins 25..36
        6'd52    // band 7: bins 37..52
    };

    // ----------------------------------------
    // accumulator FSM
    // ----------------------------------------

    typedef enum logic {
        acc_idle = 1'b0,   // waiting for frame start
        acc_run  = 1'b1    // inside a frame, counting bins
    } acc_state_t;

endpackage

//--- src/square_sum.sv
// two-stage squarer that turns a signed complex bin into real^2 + imag^2 for the square root
`timescale 1ns/1ns

module square_sum (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     bin_valid,
    input  logic                                     frame_start,
    input  logic signed [ap_parameters::FFT_DATA_WIDTH-1:0] real_part,
    input  logic signed [ap_parameters::FFT_DATA_WIDTH-1:0] imag_part,
    output logic                                     sq_valid,
    output logic                                     sq_frame_start,
    output logic        [ap_parameters::SQ_WIDTH-1:0] sum_squares
);

    // stage 1 registers
    logic                                       s1_valid;
    logic                                       s1_frame_start;
    logic signed [ap_parameters::SQ_WIDTH-1:0]  real_sq;   // max 2^30 and never negative
    logic signed [ap_parameters::SQ_WIDTH-1:0]  imag_sq;

    // ----------------------------------------
    // flags shift along for 2 cycles
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid       <= 1'b0;
            s1_frame_start <= 1'b0;
            sq_valid       <= 1'b0;
            sq_frame_start <= 1'b0;
        end else begin
            s1_valid       <= bin_valid;
            s1_frame_start <= frame_start & bin_valid;   // flag only meaningful with a bin
            sq_valid       <= s1_valid;
            sq_frame_start <= s1_frame_start;
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        // operands sign-extend to 32 bits before the multiply
        real_sq <= ap_parameters::SQ_WIDTH'(real_part) * ap_parameters::SQ_WIDTH'(real_part);
        imag_sq <= ap_parameters::SQ_WIDTH'(imag_part) * ap_parameters::SQ_WIDTH'(imag_part);
        // both squares non-negative so the sum fits unsigned 32 bits
        sum_squares <= $unsigned(real_sq) + $unsigned(imag_sq);
    end

endmodule

//--- src/isqrt_pipe.sv
// pipelined restoring integer square root, one root bit per stage, floor result every cycle
`timescale 1ns/1ns

module isqrt_pipe #(
    parameter int RADICAND_WIDTH = 32   // must be even
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic                          in_frame_start,
    input  logic [RADICAND_WIDTH-1:0]     radicand,
    output logic                          out_valid,
    output logic                          out_frame_start,
    output logic [RADICAND_WIDTH/2-1:0]   root
);

    localparam int ROOT_WIDTH = RADICAND_WIDTH / 2;
    localparam int STAGES     = ROOT_WIDTH;         // one bit decided per stage

    // index s = inputs of stage s, index 0 fed from the ports
    logic [RADICAND_WIDTH-1:0] rad_q  [0:STAGES-1];   // unconsumed radicand, msb aligned
    logic [RADICAND_WIDTH-1:0] rem_q  [0:STAGES-1];   // partial remainder
    logic [ROOT_WIDTH-1:0]     root_q [0:STAGES];     // partial root, grows from lsb
    logic [STAGES:0]           valid_q;
    logic [STAGES:0]           frame_q;

    assign rad_q[0]   = radicand;
    assign rem_q[0]   = '0;
    assign root_q[0]  = '0;
    assign valid_q[0] = in_valid;
    assign frame_q[0] = in_frame_start;

    // ----------------------------------------
    // stage chain
    // ----------------------------------------
    for (genvar s = 0; s < STAGES; s++) begin : stage_g
        logic [RADICAND_WIDTH-1:0] rem_shift;   // remainder with next two radicand bits
        logic [RADICAND_WIDTH-1:0] trial;       // 4*root + 1
        logic                      bit_set;     // trial fits, root bit is 1

        assign rem_shift = {rem_q[s][RADICAND_WIDTH-3:0], rad_q[s][RADICAND_WIDTH-1 -: 2]};
        assign trial     = {{(RADICAND_WIDTH-ROOT_WIDTH-2){1'b0}}, root_q[s], 2'b01};
        assign bit_set   = (rem_shift >= trial);

        // sideband flags ride along with the data
        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q[s+1] <= 1'b0;
                frame_q[s+1] <= 1'b0;
            end else begin
                valid_q[s+1] <= valid_q[s];
                frame_q[s+1] <= frame_q[s];
            end
        end

        always_ff @(posedge clk) begin
            root_q[s+1] <= {root_q[s][ROOT_WIDTH-2:0], bit_set};
        end

        // last stage only needs the root bit
        if (s < STAGES - 1) begin : carry_g
            always_ff @(posedge clk) begin
                rad_q[s+1] <= {rad_q[s][RADICAND_WIDTH-3:0], 2'b00};   // consume two bits
                if (bit_set) begin
                    rem_q[s+1] <= rem_shift - trial;   // restoring step
                end else begin
                    rem_q[s+1] <= rem_shift;
                end
            end
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign out_valid       = valid_q[STAGES];
    assign out_frame_start = frame_q[STAGES];
    assign root            = root_q[STAGES];   // floor(sqrt(radicand))

endmodule

//--- src/band_accumulator.sv
// sums magnitudes over each rectangular band of a frame and emits one registered energy per band
`timescale 1ns/1ns

module band_accumulator (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       mag_valid,
    input  logic                                       mag_frame_start,
    input  logic [ap_parameters::MAG_WIDTH-1:0]        magnitude,
    output logic                                       band_valid,
    output logic [mel_band_pkg::BAND_IDX_WIDTH-1:0]    band_index,
    output logic [ap_parameters::MEL_DATA_WIDTH-1:0]   band_energy
);

    localparam logic [mel_band_pkg::BAND_IDX_WIDTH-1:0] LAST_BAND =
        mel_band_pkg::BAND_IDX_WIDTH'(mel_band_pkg::NUM_BANDS - 1);

    // ----------------------------------------
    // state and running sums
    // ----------------------------------------
    mel_band_pkg::acc_state_t                    state, state_nxt;
    logic [ap_parameters::BIN_IDX_WIDTH-1:0]     bin_cnt, bin_cnt_nxt;     // bin of next magnitude
    logic [mel_band_pkg::BAND_IDX_WIDTH-1:0]     band_sel, band_sel_nxt;   // band being summed
    logic [ap_parameters::MEL_DATA_WIDTH-1:0]    acc;                      // partial band sum

    // view of the current bin, frame start overrides the counters
    logic                                        in_frame;
    logic                                        band_done;
    logic [ap_parameters::BIN_IDX_WIDTH-1:0]     cur_bin;
    logic [mel_band_pkg::BAND_IDX_WIDTH-1:0]     cur_band;
    logic [ap_parameters::MEL_DATA_WIDTH-1:0]    cur_sum;

    always_comb begin
        // frame start restarts the count, partial band dropped
        cur_bin  = mag_frame_start ? '0 : bin_cnt;
        cur_band = mag_frame_start ? '0 : band_sel;
        cur_sum  = (mag_frame_start ? '0 : acc) + ap_parameters::MEL_DATA_WIDTH'(magnitude);

        // outside a frame valid magnitudes are ignored
        in_frame  = mag_valid && (mag_frame_start || state == mel_band_pkg::acc_run);
        band_done = in_frame && (cur_bin == mel_band_pkg::BAND_LAST_BIN[cur_band]);
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_nxt    = state;
        bin_cnt_nxt  = bin_cnt;
        band_sel_nxt = band_sel;
        if (in_frame) begin
            state_nxt    = mel_band_pkg::acc_run;
            bin_cnt_nxt  = cur_bin + 1'b1;
            band_sel_nxt = cur_band;
            if (band_done) begin
                band_sel_nxt = cur_band + 1'b1;   // wraps to 0 after the last band
                if (cur_band == LAST_BAND) begin
                    state_nxt = mel_band_pkg::acc_idle;   // tail bins 53..63 ignored
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= mel_band_pkg::acc_idle;
            bin_cnt    <= '0;
            band_sel   <= '0;
            band_valid <= 1'b0;
        end else begin
            state      <= state_nxt;
            bin_cnt    <= bin_cnt_nxt;
            band_sel   <= band_sel_nxt;
            band_valid <= band_done;   // 1 cycle after the closing bin
        end
    end

    // ----------------------------------------
    // sum and output registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (in_frame) begin
            acc <= band_done ? '0 : cur_sum;   // clear for the next band
        end
        if (band_done) begin
            band_index  <= cur_band;
            band_energy <= cur_sum;   // includes the closing bin
        end
    end

endmodule

//--- src/magnitude_top.sv
// spectral magnitude stage top, bin in, magnitude after 18 cycles, band energies after 19
`timescale 1ns/1ns

module magnitude_top #(
    parameter int RADICAND_WIDTH = ap_parameters::SQ_WIDTH   // root width = half of this
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            bin_valid,
    input  logic                                            frame_start,   // with bin 0
    input  logic signed [ap_parameters::FFT_DATA_WIDTH-1:0] real_part,
    input  logic signed [ap_parameters::FFT_DATA_WIDTH-1:0] imag_part,
    output logic                                            mag_valid,
    output logic        [ap_parameters::MAG_WIDTH-1:0]      magnitude,
    output logic                                            band_valid,
    output logic        [mel_band_pkg::BAND_IDX_WIDTH-1:0]  band_index,
    output logic        [ap_parameters::MEL_DATA_WIDTH-1:0] band_energy
);

    // ----------------------------------------
    // interstage wires
    // ----------------------------------------
    logic                                sq_valid;
    logic                                sq_frame_start;
    logic [RADICAND_WIDTH-1:0]           sum_squares;
    logic                                root_valid;
    logic                                root_frame_start;
    logic [RADICAND_WIDTH/2-1:0]         root;

    assign mag_valid = root_valid;
    assign magnitude = root;

    // real^2 + imag^2, 2 cycles
    square_sum square_sum_i (
        .clk            (clk),
        .rst            (rst),
        .bin_valid      (bin_valid),
        .frame_start    (frame_start),
        .real_part      (real_part),
        .imag_part      (imag_part),
        .sq_valid       (sq_valid),
        .sq_frame_start (sq_frame_start),
        .sum_squares    (sum_squares)
    );

    // floor root, 16 cycles at default width
    isqrt_pipe #(
        .RADICAND_WIDTH (RADICAND_WIDTH)
    ) isqrt_pipe_i (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (sq_valid),
        .in_frame_start  (sq_frame_start),
        .radicand        (sum_squares),
        .out_valid       (root_valid),
        .out_frame_start (root_frame_start),
        .root            (root)
    );

    // per-band sums, registered output
    band_accumulator band_accumulator_i (
        .clk             (clk),
        .rst             (rst),
        .mag_valid       (root_valid),
        .mag_frame_start (root_frame_start),
        .magnitude       (root),
        .band_valid      (band_valid),
        .band_index      (band_index),
        .band_energy     (band_energy)
    );

endmodule

//--- tests/tb_clock.sv
// testbench clock and reset source, 4 ns period with reset held for the first 5 rising edges
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int RESET_CYCLES = 5;

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;   // released just after the 5th edge
    end

endmodule

//--- tests/magnitude_properties.sv
// concurrent checks for latency, reset and band index, bound onto every magnitude_top instance
`timescale 1ns/1ns

module magnitude_properties (
    input logic                                     clk,
    input logic                                     rst,
    input logic                                     bin_valid,
    input logic                                     mag_valid,
    input logic                                     band_valid,
    input logic [mel_band_pkg::BAND_IDX_WIDTH-1:0]  band_index
);

    // ----------------------------------------
    // latency and valid hygiene
    // ----------------------------------------

    // every accepted bin leaves the root 18 cycles later
    mag_latency_a: assert property (@(posedge clk) disable iff (rst)
        bin_valid |-> ##18 mag_valid)
        else $error("magnitude missing 18 cycles after a bin");

    // valid flops are clear from the second reset edge on
    reset_quiet_a: assert property (@(posedge clk)
        rst && $past(rst) |-> !mag_valid && !band_valid)
        else $error("valid output seen during reset");

    band_range_a: assert property (@(posedge clk) disable iff (rst)
        band_valid |-> band_index < mel_band_pkg::NUM_BANDS)
        else $error("band index out of range");

endmodule

bind magnitude_top magnitude_properties magnitude_properties_i (
    .clk        (clk),
    .rst        (rst),
    .bin_valid  (bin_valid),
    .mag_valid  (mag_valid),
    .band_valid (band_valid),
    .band_index (band_index)
);

//--- tests/magnitude_tb.sv
// testbench that replays the vector file into the magnitude top and checks magnitudes and bands
`timescale 1ns/1ns

module magnitude_tb;

    localparam int LATENCY      = 18;   // bin_valid to mag_valid
    localparam int RESET_CYCLES = 5;
    localparam int MAX_GAP      = 3;    // most random idle cycles before one bin

    logic                                            clk;
    logic                                            rst;
    logic                                            bin_valid;
    logic                                            frame_start;
    logic signed [ap_parameters::FFT_DATA_WIDTH-1:0] real_part;
    logic signed [ap_parameters::FFT_DATA_WIDTH-1:0] imag_part;
    logic                                            mag_valid;
    logic        [ap_parameters::MAG_WIDTH-1:0]      magnitude;
    logic                                            band_valid;
    logic        [mel_band_pkg::BAND_IDX_WIDTH-1:0]  band_index;
    logic        [ap_parameters::MEL_DATA_WIDTH-1:0] band_energy;

    // ----------------------------------------
    // records read from the vector file
    // ----------------------------------------
    string rec_name [$];
    int    rec_re [$];
    int    rec_im [$];
    int    rec_fs [$];
    int    rec_mag [$];
    int    rec_cnt [$];
    int    rec_gap [$];

    // expected outputs in input order
    string                                       mag_name_q [$];
    logic [ap_parameters::MAG_WIDTH-1:0]         mag_exp_q [$];
    int                                          mag_cycle_q [$];   // cycle of the input
    bit                                          mag_last_q [$];    // last bin of its record
    logic [mel_band_pkg::BAND_IDX_WIDTH-1:0]     band_idx_q [$];
    logic [ap_parameters::MEL_DATA_WIDTH-1:0]    band_exp_q [$];

    int cycle;
    int limit;
    int errors;
    int checks;
    int test_errs;   // errors within the current record
    int seed;

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    magnitude_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .bin_valid   (bin_valid),
        .frame_start (frame_start),
        .real_part   (real_part),
        .imag_part   (imag_part),
        .mag_valid   (mag_valid),
        .magnitude   (magnitude),
        .band_valid  (band_valid),
        .band_index  (band_index),
        .band_energy (band_energy)
    );

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_mag(input string name,
                             input logic [ap_parameters::MAG_WIDTH-1:0] exp_mag,
                             input logic [ap_parameters::MAG_WIDTH-1:0] act_mag);
        checks++;
        if (act_mag !== exp_mag) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp_mag, act_mag);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_band(input string name,
                              input logic [mel_band_pkg::BAND_IDX_WIDTH-1:0] exp_idx,
                              input logic [mel_band_pkg::BAND_IDX_WIDTH-1:0] act_idx,
                              input logic [ap_parameters::MEL_DATA_WIDTH-1:0] exp_e,
                              input logic [ap_parameters::MEL_DATA_WIDTH-1:0] act_e);
        checks++;
        if (act_idx !== exp_idx || act_e !== exp_e) begin
            $display("[FAIL] %s expected %0d/%0d actual %0d/%0d",
                     name, exp_idx, exp_e, act_idx, act_e);
            errors++;
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    f;
        string tag;
        string name;
        string line;
        fd = $fopen("tests/magnitude_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "B") begin
                    void'($fscanf(fd, "%s %d %d %d %d %d %d", name, a, b, c, d, e, f));
                    rec_name.push_back(name);
                    rec_re.push_back(a);
                    rec_im.push_back(b);
                    rec_fs.push_back(c);
                    rec_mag.push_back(d);
                    rec_cnt.push_back(e);
                    rec_gap.push_back(f);
                end else if (tag == "E") begin
                    void'($fscanf(fd, "%d %d", a, b));
                    band_idx_q.push_back(a[mel_band_pkg::BAND_IDX_WIDTH-1:0]);
                    band_exp_q.push_back(b);
                end else begin
                    void'($fgets(line, fd));   // comment line
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // cycle counter and timeout
    // ----------------------------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle > limit) begin
            $display("timeout after %0d cycles with outputs still pending", cycle);
            $display("TB FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        int drive_cycles;
        int g;
        bin_valid   = 1'b0;
        frame_start = 1'b0;
        real_part   = '0;
        imag_part   = '0;
        cycle       = 0;
        limit       = 0;
        errors      = 0;
        checks      = 0;
        test_errs   = 0;
        seed        = 67;
        drive_cycles = 0;
        read_vectors();
        foreach (rec_cnt[i]) begin
            drive_cycles += rec_cnt[i] * (rec_gap[i] != 0 ? MAX_GAP + 1 : 1);
        end
        limit = drive_cycles + RESET_CYCLES + LATENCY + 20;

        @(negedge rst);
        foreach (rec_name[i]) begin
            for (int n = 0; n < rec_cnt[i]; n++) begin
                g = (rec_gap[i] != 0) ? {$random(seed)} % (MAX_GAP + 1) : 0;
                repeat (g) begin   // idle gap
                    @(posedge clk);
                    #1;
                    bin_valid   = 1'b0;
                    frame_start = 1'b0;
                end
                @(posedge clk);
                #1;
                bin_valid   = 1'b1;
                frame_start = (n == 0) && (rec_fs[i] != 0);   // only first bin of a record
                real_part   = ap_parameters::FFT_DATA_WIDTH'(rec_re[i]);
                imag_part   = ap_parameters::FFT_DATA_WIDTH'(rec_im[i]);
                mag_name_q.push_back(rec_name[i]);
                mag_exp_q.push_back(ap_parameters::MAG_WIDTH'(rec_mag[i]));
                mag_cycle_q.push_back(cycle);
                mag_last_q.push_back(n == rec_cnt[i] - 1);
            end
        end
        @(posedge clk);
        #1;
        bin_valid   = 1'b0;
        frame_start = 1'b0;

        while (mag_exp_q.size() != 0 || band_exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);   // room for stray pulses

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ----------------------------------------
    // monitor sampled mid-cycle on the falling edge
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst && mag_valid) begin
            if (mag_exp_q.size() == 0) begin
                $display("magnitude pulse with no bin pending");
                errors++;
            end else begin
                if (cycle - mag_cycle_q[0] != LATENCY) begin
                    $display("%s came out %0d cycles after its bin instead of %0d",
                             mag_name_q[0], cycle - mag_cycle_q[0], LATENCY);
                    errors++;
                    test_errs++;
                end
                check_mag(mag_name_q[0], mag_exp_q[0], magnitude);
                if (mag_last_q[0]) begin
                    $display("%s: %s", mag_name_q[0], test_errs == 0 ? "ok" : "fail");
                    test_errs = 0;
                end
                void'(mag_name_q.pop_front());
                void'(mag_exp_q.pop_front());
                void'(mag_cycle_q.pop_front());
                void'(mag_last_q.pop_front());
            end
        end
        if (!rst && band_valid) begin
            if (band_exp_q.size() == 0) begin
                $display("band pulse for band %0d with none expected", band_index);
                errors++;
            end else begin
                check_band($sformatf("band_%0d", band_idx_q[0]), band_idx_q[0], band_index,
                           band_exp_q[0], band_energy);
                void'(band_idx_q.pop_front());
                void'(band_exp_q.pop_front());
            end
        end
    end

endmodule

//--- tests/magnitude_vectors.txt
# B name real imag frame_start expected_mag repeat random_gap
# E band_index expected_energy
B zero 0 0 0 0 1 0
B axis_neg_re -300 0 0 300 1 0
B axis_neg_im 0 -1234 0 1234 1 0
B axis_max 32767 0 0 32767 1 0
B axis_min -32768 0 0 32768 1 0
B gen_3_4 3 4 0 5 1 0
B gen_1_1 1 1 0 1 1 0
B gen_2_2 2 2 0 2 1 0
B gen_100_m7 100 -7 0 100 1 0
B gen_m5_12 -5 12 0 13 1 0
B gen_min_min -32768 -32768 0 46340 1 0
B stream_b2b 6 8 0 10 8 0
B stream_gap -9 12 0 15 10 1
B frame_a 3 4 1 5 1 0
B frame_b 3 4 0 5 10 0
B frame_c 8 -15 0 17 14 0
B frame_d 20 21 0 29 28 0
B frame_tail 100 0 0 100 11 0
E 0 10
E 1 10
E 2 15
E 3 20
E 4 102
E 5 136
E 6 348
E 7 464
B restart_a 1 0 1 1 1 0
B restart_b 2 0 0 2 4 0
B restart_c 7 24 1 25 1 0
B restart_d 0 -6 0 6 1 0
E 0 3
E 1 4
E 0 31

//--- tb.f
src/ap_parameters.sv
src/mel_band_pkg.sv
src/square_sum.sv
src/isqrt_pipe.sv
src/band_accumulator.sv
src/magnitude_top.sv
tests/tb_clock.sv
tests/magnitude_properties.sv
tests/magnitude_tb.sv

//--- Makefile
# Verilator build and run for the magnitude testbench

SRCS := $(wildcard src/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vmagnitude_tb: $(SRCS) tb.f
	verilator --binary --timing --assert --top-module magnitude_tb -f tb.f -o Vmagnitude_tb

run: obj_dir/Vmagnitude_tb
	./obj_dir/Vmagnitude_tb | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
